/* Makefile */
VERILATOR  := verilator
TOP        := cpu_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
common/isa_pkg.sv
common/cpu_pkg.sv
hw/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
tb/tb_clock.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

/* common/cpu_pkg.sv */
// Datapath widths and internal selector encodings. Memory depths here are only top-level defaults.
package cpu_pkg;

   localparam int word_w = 32;
   typedef logic [word_w-1:0] word_t;

   // Default memory sizes as address bits of 32-bit words
   localparam int imem_aw_default = 8;
   localparam int dmem_aw_default = 8;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt
   } alu_op_t;

   // Operand source in execute
   typedef enum logic [1:0] {
      fwd_none,
      fwd_ex_mem,
      fwd_mem_wb
   } fwd_sel_t;

endpackage

/* common/isa_pkg.sv */
// Encodings cover only add, sub, and, or, slt, addi, lw and sw. Branch, jump and shift codes are absent.
package isa_pkg;

   // Primary opcodes
   localparam logic [5:0] op_rtype = 6'd0;
   localparam logic [5:0] op_addi  = 6'd8;
   localparam logic [5:0] op_lw    = 6'd35;
   localparam logic [5:0] op_sw    = 6'd43;

   // R-type function codes, opcode zero with function zero is a no-op
   localparam logic [5:0] fn_add = 6'd32;
   localparam logic [5:0] fn_sub = 6'd34;
   localparam logic [5:0] fn_and = 6'd36;
   localparam logic [5:0] fn_or  = 6'd37;
   localparam logic [5:0] fn_slt = 6'd42;

   // Register index, r0 reads as zero
   typedef logic [4:0] reg_idx_t;

   // Field positions inside the 32-bit instruction word
   localparam int op_lsb = 26;
   localparam int rs_lsb = 21;
   localparam int rt_lsb = 16;
   localparam int rd_lsb = 11;

endpackage

/* decode/decode_stage.sv */
// Unknown opcodes and function codes decode as no-ops. Stall covers only a load directly ahead of a user.
`timescale 1ns/1ns

module decode_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  cpu_pkg::word_t    if_instr,
   input  logic              ex_mem_read_fb,
   input  isa_pkg::reg_idx_t ex_dst_fb,
   input  logic              wb_we,
   input  isa_pkg::reg_idx_t wb_dst,
   input  cpu_pkg::word_t    wb_data,
   output logic              stall,
   output isa_pkg::reg_idx_t ex_rs,
   output isa_pkg::reg_idx_t ex_rt,
   output isa_pkg::reg_idx_t ex_dst,
   output cpu_pkg::word_t    ex_a,
   output cpu_pkg::word_t    ex_b,
   output cpu_pkg::word_t    ex_imm,
   output cpu_pkg::alu_op_t  ex_alu_op,
   output logic              ex_use_imm,
   output logic              ex_mem_read,
   output logic              ex_mem_write,
   output logic              ex_reg_write
);

   logic [5:0]        opcode;
   logic [5:0]        funct;
   isa_pkg::reg_idx_t rs;
   isa_pkg::reg_idx_t rt;
   isa_pkg::reg_idx_t rd;
   isa_pkg::reg_idx_t dst;
   cpu_pkg::word_t    imm;
   cpu_pkg::word_t    rdata_1;
   cpu_pkg::word_t    rdata_2;
   cpu_pkg::alu_op_t  alu_op;
   logic              use_imm;
   logic              mem_read;
   logic              mem_write;
   logic              reg_write;
   logic              rf_we;

   assign opcode = if_instr[isa_pkg::op_lsb +: 6];
   assign rs     = if_instr[isa_pkg::rs_lsb +: 5];
   assign rt     = if_instr[isa_pkg::rt_lsb +: 5];
   assign rd     = if_instr[isa_pkg::rd_lsb +: 5];
   assign funct  = if_instr[5:0];
   assign imm    = {{16{if_instr[15]}}, if_instr[15:0]};

   //////////////////////////////
   // Control decode
   always_comb begin
      alu_op    = cpu_pkg::alu_add;
      use_imm   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      reg_write = 1'b0;
      dst       = rt;
      case (opcode)
         isa_pkg::op_rtype: begin
            dst       = rd;
            reg_write = 1'b1;
            case (funct)
               isa_pkg::fn_add: alu_op = cpu_pkg::alu_add;
               isa_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
               isa_pkg::fn_and: alu_op = cpu_pkg::alu_and;
               isa_pkg::fn_or:  alu_op = cpu_pkg::alu_or;
               isa_pkg::fn_slt: alu_op = cpu_pkg::alu_slt;
               // Includes function zero, the no-op
               default: reg_write = 1'b0;
            endcase
         end
         isa_pkg::op_addi: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         isa_pkg::op_lw: begin
            use_imm   = 1'b1;
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         isa_pkg::op_sw: begin
            use_imm   = 1'b1;
            mem_write = 1'b1;
         end
         default: reg_write = 1'b0;
      endcase
   end

   // Load in EX feeding this instruction
   assign stall = ex_mem_read_fb && (ex_dst_fb != '0) &&
                  ((ex_dst_fb == rs) || (ex_dst_fb == rt));

   // Writeback lands only on run-high edges
   assign rf_we = wb_we && run;

   register_file u_register_file (
      .clk     (clk),
      .raddr_1 (rs),
      .raddr_2 (rt),
      .we      (rf_we),
      .waddr   (wb_dst),
      .wdata   (wb_data),
      .rdata_1 (rdata_1),
      .rdata_2 (rdata_2)
   );

   //////////////////////////////
   // ID/EX register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_alu_op    <= cpu_pkg::alu_add;
         ex_use_imm   <= 1'b0;
         ex_mem_read  <= 1'b0;
         ex_mem_write <= 1'b0;
         ex_reg_write <= 1'b0;
      end else if (run) begin
         ex_alu_op    <= alu_op;
         ex_use_imm   <= use_imm;
         // Bubble while stalled
         ex_mem_read  <= mem_read && !stall;
         ex_mem_write <= mem_write && !stall;
         ex_reg_write <= reg_write && !stall;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         ex_rs  <= rs;
         ex_rt  <= rt;
         ex_dst <= dst;
         ex_a   <= rdata_1;
         ex_b   <= rdata_2;
         ex_imm <= imm;
      end
   end

endmodule

/* decode/register_file.sv */
// Registers are not reset. A write to r0 is dropped and a same-cycle write bypasses to the reads.
`timescale 1ns/1ns

module register_file (
   input  logic              clk,
   input  isa_pkg::reg_idx_t raddr_1,
   input  isa_pkg::reg_idx_t raddr_2,
   input  logic              we,
   input  isa_pkg::reg_idx_t waddr,
   input  cpu_pkg::word_t    wdata,
   output cpu_pkg::word_t    rdata_1,
   output cpu_pkg::word_t    rdata_2
);

   cpu_pkg::word_t regs [2**$bits(isa_pkg::reg_idx_t)];

   always_ff @(posedge clk) begin
      if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // r0 first, then write-before-read bypass
   assign rdata_1 = (raddr_1 == '0) ? '0 :
                    (we && (waddr == raddr_1)) ? wdata : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0) ? '0 :
                    (we && (waddr == raddr_2)) ? wdata : regs[raddr_2];

endmodule

/* hw/cpu_top.sv */
// Load instruction memory and read data memory only while run is low. There are no branches.
`timescale 1ns/1ns

module cpu_top #(
   parameter int imem_addr_w = cpu_pkg::imem_aw_default,
   parameter int dmem_addr_w = cpu_pkg::dmem_aw_default
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic                   imem_wen,
   input  logic [imem_addr_w-1:0] imem_addr,
   input  cpu_pkg::word_t         imem_wdata,
   input  logic [dmem_addr_w-1:0] dmem_raddr,
   output cpu_pkg::word_t         dmem_rdata
);

   cpu_pkg::word_t    if_instr;
   logic              stall;
   isa_pkg::reg_idx_t ex_rs;
   isa_pkg::reg_idx_t ex_rt;
   isa_pkg::reg_idx_t ex_dst;
   cpu_pkg::word_t    ex_a;
   cpu_pkg::word_t    ex_b;
   cpu_pkg::word_t    ex_imm;
   cpu_pkg::alu_op_t  ex_alu_op;
   logic              ex_use_imm;
   logic              ex_mem_read;
   logic              ex_mem_write;
   logic              ex_reg_write;
   cpu_pkg::word_t    mem_alu;
   cpu_pkg::word_t    mem_store;
   isa_pkg::reg_idx_t mem_dst;
   logic              mem_read;
   logic              mem_write;
   logic              mem_reg_write;
   logic              wb_we;
   isa_pkg::reg_idx_t wb_dst;
   cpu_pkg::word_t    wb_data;

   fetch_stage #(
      .imem_addr_w (imem_addr_w)
   ) u_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .stall      (stall),
      .imem_wen   (imem_wen),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .if_instr   (if_instr)
   );

   // EX load and destination go back to decode for hazard detection
   decode_stage u_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .run            (run),
      .if_instr       (if_instr),
      .ex_mem_read_fb (ex_mem_read),
      .ex_dst_fb      (ex_dst),
      .wb_we          (wb_we),
      .wb_dst         (wb_dst),
      .wb_data        (wb_data),
      .stall          (stall),
      .ex_rs          (ex_rs),
      .ex_rt          (ex_rt),
      .ex_dst         (ex_dst),
      .ex_a           (ex_a),
      .ex_b           (ex_b),
      .ex_imm         (ex_imm),
      .ex_alu_op      (ex_alu_op),
      .ex_use_imm     (ex_use_imm),
      .ex_mem_read    (ex_mem_read),
      .ex_mem_write   (ex_mem_write),
      .ex_reg_write   (ex_reg_write)
   );

   execute_stage u_execute (
      .clk           (clk),
      .rst_n         (rst_n),
      .run           (run),
      .ex_rs         (ex_rs),
      .ex_rt         (ex_rt),
      .ex_dst        (ex_dst),
      .ex_a          (ex_a),
      .ex_b          (ex_b),
      .ex_imm        (ex_imm),
      .ex_alu_op     (ex_alu_op),
      .ex_use_imm    (ex_use_imm),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_reg_write  (ex_reg_write),
      .wb_we         (wb_we),
      .wb_dst        (wb_dst),
      .wb_data       (wb_data),
      .mem_alu       (mem_alu),
      .mem_store     (mem_store),
      .mem_dst       (mem_dst),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .mem_reg_write (mem_reg_write)
   );

   memory_stage #(
      .dmem_addr_w (dmem_addr_w)
   ) u_memory (
      .clk           (clk),
      .rst_n         (rst_n),
      .run           (run),
      .mem_alu       (mem_alu),
      .mem_store     (mem_store),
      .mem_dst       (mem_dst),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .mem_reg_write (mem_reg_write),
      .dmem_raddr    (dmem_raddr),
      .dmem_rdata    (dmem_rdata),
      .wb_we         (wb_we),
      .wb_dst        (wb_dst),
      .wb_data       (wb_data)
   );

endmodule

/* hw/execute_stage.sv */
// EX/MEM forwarding passes the ALU result. A load result can reach execute only from MEM/WB.
`timescale 1ns/1ns

module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  isa_pkg::reg_idx_t ex_rs,
   input  isa_pkg::reg_idx_t ex_rt,
   input  isa_pkg::reg_idx_t ex_dst,
   input  cpu_pkg::word_t    ex_a,
   input  cpu_pkg::word_t    ex_b,
   input  cpu_pkg::word_t    ex_imm,
   input  cpu_pkg::alu_op_t  ex_alu_op,
   input  logic              ex_use_imm,
   input  logic              ex_mem_read,
   input  logic              ex_mem_write,
   input  logic              ex_reg_write,
   input  logic              wb_we,
   input  isa_pkg::reg_idx_t wb_dst,
   input  cpu_pkg::word_t    wb_data,
   output cpu_pkg::word_t    mem_alu,
   output cpu_pkg::word_t    mem_store,
   output isa_pkg::reg_idx_t mem_dst,
   output logic              mem_read,
   output logic              mem_write,
   output logic              mem_reg_write
);

   cpu_pkg::fwd_sel_t fwd_a;
   cpu_pkg::fwd_sel_t fwd_b;
   cpu_pkg::word_t    opnd_a;
   cpu_pkg::word_t    opnd_rt;
   cpu_pkg::word_t    opnd_b;
   cpu_pkg::word_t    alu_y;
   logic              lt;

   // Younger result wins
   function automatic cpu_pkg::fwd_sel_t pick_fwd(isa_pkg::reg_idx_t src);
      cpu_pkg::fwd_sel_t sel;
      if (mem_reg_write && (mem_dst != '0) && (mem_dst == src)) begin
         sel = cpu_pkg::fwd_ex_mem;
      end else if (wb_we && (wb_dst != '0) && (wb_dst == src)) begin
         sel = cpu_pkg::fwd_mem_wb;
      end else begin
         sel = cpu_pkg::fwd_none;
      end
      return sel;
   endfunction

   function automatic cpu_pkg::word_t fwd_value(cpu_pkg::fwd_sel_t sel,
                                               cpu_pkg::word_t reg_val);
      cpu_pkg::word_t val;
      case (sel)
         cpu_pkg::fwd_ex_mem: val = mem_alu;
         cpu_pkg::fwd_mem_wb: val = wb_data;
         default:             val = reg_val;
      endcase
      return val;
   endfunction

   //////////////////////////////
   // Operand selection
   always_comb begin
      fwd_a   = pick_fwd(ex_rs);
      fwd_b   = pick_fwd(ex_rt);
      opnd_a  = fwd_value(fwd_a, ex_a);
      // Also the store data
      opnd_rt = fwd_value(fwd_b, ex_b);
      opnd_b  = ex_use_imm ? ex_imm : opnd_rt;
   end

   // Signed compare for slt
   assign lt = $signed(opnd_a) < $signed(opnd_b);

   always_comb begin
      case (ex_alu_op)
         cpu_pkg::alu_sub: alu_y = opnd_a - opnd_b;
         cpu_pkg::alu_and: alu_y = opnd_a & opnd_b;
         cpu_pkg::alu_or:  alu_y = opnd_a | opnd_b;
         cpu_pkg::alu_slt: alu_y = {{(cpu_pkg::word_w-1){1'b0}}, lt};
         default:          alu_y = opnd_a + opnd_b;
      endcase
   end

   //////////////////////////////
   // EX/MEM register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_read      <= 1'b0;
         mem_write     <= 1'b0;
         mem_reg_write <= 1'b0;
      end else if (run) begin
         mem_read      <= ex_mem_read;
         mem_write     <= ex_mem_write;
         mem_reg_write <= ex_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         mem_alu   <= alu_y;
         mem_store <= opnd_rt;
         mem_dst   <= ex_dst;
      end
   end

endmodule

/* hw/fetch_stage.sv */
// Instruction memory is not reset and the PC wraps. Load unused words with zero and write only while run is low.
`timescale 1ns/1ns

module fetch_stage #(
   parameter int imem_addr_w = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic                   stall,
   input  logic                   imem_wen,
   input  logic [imem_addr_w-1:0] imem_addr,
   input  cpu_pkg::word_t         imem_wdata,
   output cpu_pkg::word_t         if_instr
);

   cpu_pkg::word_t         imem [2**imem_addr_w];
   logic [imem_addr_w-1:0] pc;
   logic                   advance;

   // PC and IF/ID hold on a freeze or a load-use stall
   assign advance = run && !stall;

   // External load port
   always_ff @(posedge clk) begin
      if (imem_wen) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   //////////////////////////////
   // PC and IF/ID register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc       <= '0;
         if_instr <= '0;
      end else if (advance) begin
         pc       <= pc + 1'b1;
         if_instr <= imem[pc];
      end
   end

endmodule

/* hw/memory_stage.sv */
// Data memory is word addressed from byte address bits and not reset. The external read has one cycle latency.
`timescale 1ns/1ns

module memory_stage #(
   parameter int dmem_addr_w = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  cpu_pkg::word_t         mem_alu,
   input  cpu_pkg::word_t         mem_store,
   input  isa_pkg::reg_idx_t      mem_dst,
   input  logic                   mem_read,
   input  logic                   mem_write,
   input  logic                   mem_reg_write,
   input  logic [dmem_addr_w-1:0] dmem_raddr,
   output cpu_pkg::word_t         dmem_rdata,
   output logic                   wb_we,
   output isa_pkg::reg_idx_t      wb_dst,
   output cpu_pkg::word_t         wb_data
);

   cpu_pkg::word_t         dmem [2**dmem_addr_w];
   logic [dmem_addr_w-1:0] daddr;
   cpu_pkg::word_t         load_word;

   // Byte address down to a word index
   assign daddr     = mem_alu[dmem_addr_w+1:2];
   assign load_word = dmem[daddr];

   always_ff @(posedge clk) begin
      if (run && mem_write) begin
         dmem[daddr] <= mem_store;
      end
   end

   // External read port
   always_ff @(posedge clk) begin
      dmem_rdata <= dmem[dmem_raddr];
   end

   //////////////////////////////
   // MEM/WB register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_we <= 1'b0;
      end else if (run) begin
         wb_we <= mem_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         wb_dst  <= mem_dst;
         wb_data <= mem_read ? load_word : mem_alu;
      end
   end

endmodule

/* tb/cpu_sva.sv */
// Bound into cpu_top. Needs assertion support enabled in the simulator to have any effect.
`timescale 1ns/1ns

module cpu_sva #(
   parameter int dmem_addr_w = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic                   stall,
   input  logic                   wb_we,
   input  isa_pkg::reg_idx_t      ex_rs,
   input  isa_pkg::reg_idx_t      ex_rt,
   input  cpu_pkg::word_t         ex_a,
   input  cpu_pkg::word_t         ex_b,
   input  logic [dmem_addr_w-1:0] dmem_raddr,
   input  cpu_pkg::word_t         dmem_rdata
);

   logic       stall_last;
   logic [2:0] run_edges;

   // Stall seen at the previous run-high edge, and run-high edges since reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stall_last <= 1'b0;
         run_edges  <= '0;
      end else if (run) begin
         stall_last <= stall;
         if (run_edges != 3'd4) begin
            run_edges <= run_edges + 3'd1;
         end
      end
   end

   //////////////////////////////
   // Data memory holds while frozen, seen through the read port
   frozen_dmem: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(!run) && $stable(dmem_raddr)) |=> $stable(dmem_rdata))
      else $error("data memory changed while run was low");

   single_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (run && stall_last) |-> !stall)
      else $error("stall held for two run-high cycles");

   r0_rs_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (ex_rs == 5'd0) |-> (ex_a == '0))
      else $error("r0 read nonzero on rs");

   r0_rt_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (ex_rt == 5'd0) |-> (ex_b == '0))
      else $error("r0 read nonzero on rt");

   // First instruction needs four run-high edges to reach MEM/WB
   quiet_writeback: assert property (@(posedge clk) disable iff (!rst_n)
      (run_edges < 3'd4) |-> !wb_we)
      else $error("writeback enabled before the first instruction arrived");

endmodule

bind cpu_top cpu_sva #(
   .dmem_addr_w (dmem_addr_w)
) u_cpu_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .run        (run),
   .stall      (stall),
   .wb_we      (wb_we),
   .ex_rs      (ex_rs),
   .ex_rt      (ex_rt),
   .ex_a       (ex_a),
   .ex_b       (ex_b),
   .dmem_raddr (dmem_raddr),
   .dmem_rdata (dmem_rdata)
);

/* tb/cpu_tb.sv */
// One straight-line program with stores from data word 0 upward. Unused instruction words are loaded as no-ops.
`timescale 1ns/1ns

module cpu_tb;

   localparam int imem_aw    = 8;
   localparam int dmem_aw    = 8;
   localparam int wait_limit = 50;
   localparam int pause_len  = 6;

   logic               clk;
   logic               rst_n;
   logic               run;
   logic               imem_wen;
   logic [imem_aw-1:0] imem_addr;
   cpu_pkg::word_t     imem_wdata;
   logic [dmem_aw-1:0] dmem_raddr;
   cpu_pkg::word_t     dmem_rdata;

   // Program image and the in-order reference model
   cpu_pkg::word_t     prog [$];
   cpu_pkg::word_t     model_regs [32];
   cpu_pkg::word_t     model_mem [2**dmem_aw];
   int                 stored_words [$];
   logic [31:0]        lcg_state;
   int                 check_errors;
   int                 timeouts;
   // Run-high edge count at the freeze, and the word its pending store targets
   int                 pause_at;
   int                 pause_slot;

   tb_clock u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   cpu_top #(
      .imem_addr_w (imem_aw),
      .dmem_addr_w (dmem_aw)
   ) DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .imem_wen   (imem_wen),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .dmem_raddr (dmem_raddr),
      .dmem_rdata (dmem_rdata)
   );

   function automatic logic [31:0] lcg_next(logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Small positive immediate from the upper LCG bits
   task automatic draw_imm(output logic [15:0] imm);
      lcg_state = lcg_next(lcg_state);
      imm = {8'h00, lcg_state[23:16]} + 16'd1;
   endtask

   function automatic cpu_pkg::word_t sext(logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   function automatic cpu_pkg::word_t enc_r(logic [5:0] fn, isa_pkg::reg_idx_t rd,
                                            isa_pkg::reg_idx_t rs, isa_pkg::reg_idx_t rt);
      cpu_pkg::word_t w;
      w = '0;
      w[isa_pkg::op_lsb +: 6] = isa_pkg::op_rtype;
      w[isa_pkg::rs_lsb +: 5] = rs;
      w[isa_pkg::rt_lsb +: 5] = rt;
      w[isa_pkg::rd_lsb +: 5] = rd;
      w[5:0]                  = fn;
      return w;
   endfunction

   function automatic cpu_pkg::word_t enc_i(logic [5:0] op, isa_pkg::reg_idx_t rt,
                                            isa_pkg::reg_idx_t rs, logic [15:0] imm);
      cpu_pkg::word_t w;
      w = '0;
      w[isa_pkg::op_lsb +: 6] = op;
      w[isa_pkg::rs_lsb +: 5] = rs;
      w[isa_pkg::rt_lsb +: 5] = rt;
      w[15:0]                 = imm;
      return w;
   endfunction

   //////////////////////////////
   // Instruction emitters that also step the model
   task automatic alu_instr(logic [5:0] fn, isa_pkg::reg_idx_t rd,
                            isa_pkg::reg_idx_t rs, isa_pkg::reg_idx_t rt);
      cpu_pkg::word_t a;
      cpu_pkg::word_t b;
      cpu_pkg::word_t y;
      a = model_regs[rs];
      b = model_regs[rt];
      case (fn)
         isa_pkg::fn_sub: y = a - b;
         isa_pkg::fn_and: y = a & b;
         isa_pkg::fn_or:  y = a | b;
         isa_pkg::fn_slt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default:         y = a + b;
      endcase
      prog.push_back(enc_r(fn, rd, rs, rt));
      if (rd != 5'd0) begin
         model_regs[rd] = y;
      end
   endtask

   task automatic addi_instr(isa_pkg::reg_idx_t rt, isa_pkg::reg_idx_t rs, logic [15:0] imm);
      prog.push_back(enc_i(isa_pkg::op_addi, rt, rs, imm));
      if (rt != 5'd0) begin
         model_regs[rt] = model_regs[rs] + sext(imm);
      end
   endtask

   // Loads and stores use r0 as base, so the offset is the byte address
   task automatic load_instr(isa_pkg::reg_idx_t rt, int slot);
      prog.push_back(enc_i(isa_pkg::op_lw, rt, 5'd0, 16'(slot * 4)));
      if (rt != 5'd0) begin
         model_regs[rt] = model_mem[slot];
      end
   endtask

   task automatic store_instr(isa_pkg::reg_idx_t rt, int slot);
      prog.push_back(enc_i(isa_pkg::op_sw, rt, 5'd0, 16'(slot * 4)));
      model_mem[slot] = model_regs[rt];
      stored_words.push_back(slot);
   endtask

   task automatic nop_instr;
      prog.push_back('0);
   endtask

   task automatic build_program;
      logic [15:0] imm_a;
      logic [15:0] imm_b;
      logic [15:0] imm_c;
      logic [15:0] imm_d;
      int          r;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      draw_imm(imm_a);
      draw_imm(imm_b);
      draw_imm(imm_c);
      draw_imm(imm_d);
      // Operands with r3 negative and gaps so the ALU ops read the register file
      addi_instr(5'd1, 5'd0, imm_a);
      addi_instr(5'd2, 5'd0, imm_b);
      addi_instr(5'd3, 5'd0, 16'd0 - imm_c);
      nop_instr();
      nop_instr();
      nop_instr();
      alu_instr(isa_pkg::fn_add, 5'd4, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_sub, 5'd5, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_and, 5'd6, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_or, 5'd7, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_slt, 5'd8, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_slt, 5'd9, 5'd3, 5'd1);
      alu_instr(isa_pkg::fn_slt, 5'd10, 5'd1, 5'd3);
      for (r = 4; r <= 10; r++) begin
         store_instr(5'(r), r - 4);
      end
      // Back-to-back dependency through EX/MEM
      alu_instr(isa_pkg::fn_add, 5'd11, 5'd1, 5'd2);
      alu_instr(isa_pkg::fn_sub, 5'd12, 5'd11, 5'd1);
      // Freeze while this store waits in EX/MEM, three run-high edges after its fetch
      pause_at   = prog.size() + 3;
      pause_slot = 7;
      store_instr(5'd12, 7);
      // Distance two through MEM/WB
      addi_instr(5'd13, 5'd2, imm_d);
      nop_instr();
      alu_instr(isa_pkg::fn_or, 5'd14, 5'd13, 5'd1);
      store_instr(5'd14, 8);
      // Write to r0 must not be forwarded or kept
      addi_instr(5'd0, 5'd1, imm_a);
      alu_instr(isa_pkg::fn_add, 5'd15, 5'd0, 5'd2);
      store_instr(5'd15, 9);
      store_instr(5'd0, 10);
      // Load-use on rs, then on rt
      load_instr(5'd16, 0);
      alu_instr(isa_pkg::fn_add, 5'd17, 5'd16, 5'd1);
      store_instr(5'd17, 11);
      load_instr(5'd18, 7);
      alu_instr(isa_pkg::fn_sub, 5'd19, 5'd1, 5'd18);
      store_instr(5'd19, 12);
   endtask

   //////////////////////////////
   // Bus-level tasks driven on the falling edge
   task automatic wait_reset_release;
      int n;
      n = 0;
      @(posedge clk);
      while (!rst_n && (n < wait_limit)) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) begin
         $display("Timeout: reset was never released");
         timeouts++;
      end
      @(negedge clk);
   endtask

   task automatic load_program;
      int i;
      for (i = 0; i < 2**imem_aw; i++) begin
         @(negedge clk);
         imem_wen   = 1'b1;
         imem_addr  = i[imem_aw-1:0];
         imem_wdata = (i < prog.size()) ? prog[i] : '0;
      end
      @(negedge clk);
      imem_wen = 1'b0;
   endtask

   task automatic run_program(int run_cycles);
      int done;
      int paused;
      int guard;
      done   = 0;
      paused = 0;
      guard  = 0;
      while ((done < run_cycles) && (guard < run_cycles + pause_len + wait_limit)) begin
         @(negedge clk);
         // Freeze with a store pending and watch its word on the read port
         if ((done == pause_at) && (paused < pause_len)) begin
            run        = 1'b0;
            dmem_raddr = pause_slot[dmem_aw-1:0];
            paused++;
         end else begin
            run = 1'b1;
            done++;
         end
         guard++;
      end
      @(negedge clk);
      run = 1'b0;
      if (done < run_cycles) begin
         $display("Timeout: program did not complete %0d run cycles", run_cycles);
         timeouts++;
      end
   endtask

   // Read port has one cycle of latency
   task automatic check_word(int slot);
      cpu_pkg::word_t exp;
      exp = model_mem[slot];
      @(negedge clk);
      dmem_raddr = slot[dmem_aw-1:0];
      @(negedge clk);
      assert (dmem_rdata == exp) else begin
         $display("CHECK FAILED: dmem_rdata word %0d expected %08h actual %08h",
                  slot, exp, dmem_rdata);
         check_errors++;
      end
   endtask

   initial begin
      run          = 1'b0;
      imem_wen     = 1'b0;
      imem_addr    = '0;
      imem_wdata   = '0;
      dmem_raddr   = '0;
      lcg_state    = 32'd23612;
      check_errors = 0;
      timeouts     = 0;
      build_program();
      wait_reset_release();
      load_program();
      run_program(prog.size() + 10);
      foreach (stored_words[k]) begin
         check_word(stored_words[k]);
      end
      $display("Errors: %0d failed checks of %0d, %0d timeouts",
               check_errors, stored_words.size(), timeouts);
      if ((check_errors == 0) && (timeouts == 0)) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* tb/tb_clock.sv */
// Free-running 20 ns clock from time zero. Reset is held low over the first three rising edges.
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Release away from the rising edge
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule
